//--- include/host_ctrl_defs.svh
// Host control domain parameters
// Bus widths, address map and register offsets of the config targets

`ifndef HOST_CTRL_DEFS_SVH
`define HOST_CTRL_DEFS_SVH

`define HC_ADDR_W         32
`define HC_DATA_W         32

// Target windows, 256 bytes each
`define HC_PMU_BASE       32'h0000_0000
`define HC_MBOX_BASE      32'h0000_0100
`define HC_WIN_MASK       32'h0000_00FF

// Performance monitor
`define HC_NUM_EVT        4
`define HC_PMU_EN_OFS     32'h00
`define HC_PMU_THR_OFS    32'h04
`define HC_PMU_CNT_OFS    32'h10

// Host-to-cluster mailbox
`define HC_MBOX_DATA_OFS  32'h00
`define HC_MBOX_BELL_OFS  32'h04
`define HC_MBOX_CLR_OFS   32'h08

`endif

//--- src/host_ctrl_pkg.sv
// Host control domain types
// AXI response codes and the cache event vector

package host_ctrl_pkg;

  // AXI4-Lite response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  // One bit per cache event, read hit in bit 0
  typedef struct packed {
    logic wr_miss;
    logic wr_hit;
    logic rd_miss;
    logic rd_hit;
  } llc_evt_t;

endpackage

//--- src/cfg_lite_if.sv
`timescale 1ns/1ns
// AXI4-Lite config link between the address splitter and one target

`include "host_ctrl_defs.svh"

interface cfg_lite_if
  import host_ctrl_pkg::*;
();

  logic                      awvalid;
  logic                      awready;
  logic [`HC_ADDR_W-1:0]     awaddr;
  logic                      wvalid;
  logic                      wready;
  logic [`HC_DATA_W-1:0]     wdata;
  logic [`HC_DATA_W/8-1:0]   wstrb;
  logic                      bvalid;
  logic                      bready;
  axi_resp_e                 bresp;
  logic                      arvalid;
  logic                      arready;
  logic [`HC_ADDR_W-1:0]     araddr;
  logic                      rvalid;
  logic                      rready;
  logic [`HC_DATA_W-1:0]     rdata;
  axi_resp_e                 rresp;

  modport mst (
    output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
    input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
  );

  modport slv (
    input  awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
    output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
  );

endinterface

//--- src/lite_demux.sv
`timescale 1ns/1ns
// AXI4-Lite address splitter
// One transaction at a time, writes before reads, window offset forwarded
// to the monitor or the mailbox; unmapped addresses get DECERR

`include "host_ctrl_defs.svh"

module lite_demux
  import host_ctrl_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     awvalid_i,
  output logic                     awready_o,
  input  logic [`HC_ADDR_W-1:0]    awaddr_i,
  input  logic                     wvalid_i,
  output logic                     wready_o,
  input  logic [`HC_DATA_W-1:0]    wdata_i,
  input  logic [`HC_DATA_W/8-1:0]  wstrb_i,
  output logic                     bvalid_o,
  input  logic                     bready_i,
  output axi_resp_e                bresp_o,
  input  logic                     arvalid_i,
  output logic                     arready_o,
  input  logic [`HC_ADDR_W-1:0]    araddr_i,
  output logic                     rvalid_o,
  input  logic                     rready_i,
  output logic [`HC_DATA_W-1:0]    rdata_o,
  output axi_resp_e                rresp_o,
  cfg_lite_if.mst                  pmu_o,
  cfg_lite_if.mst                  mbox_o
);

  typedef enum logic [1:0] {ST_IDLE, ST_FWD, ST_RESP} state_e;
  typedef enum logic [1:0] {SEL_NONE, SEL_PMU, SEL_MBOX} sel_e;

  state_e                  state_q;
  sel_e                    sel_q;
  sel_e                    sel_d;
  logic                    is_wr_q;
  logic                    sent_q;
  logic                    wr_go;
  logic                    rd_go;
  logic [`HC_ADDR_W-1:0]   cap_addr;
  logic [`HC_ADDR_W-1:0]   cap_win;
  logic [`HC_ADDR_W-1:0]   addr_q;
  logic [`HC_DATA_W-1:0]   wdata_q;
  logic [`HC_DATA_W/8-1:0] wstrb_q;
  logic                    req_vld;
  logic                    t_acc;
  logic                    t_done;
  axi_resp_e               t_resp;
  logic [`HC_DATA_W-1:0]   t_rdata;
  axi_resp_e               resp_q;
  logic [`HC_DATA_W-1:0]   rdata_q;

  // A pending write address blocks reads until its data arrives
  assign wr_go = (state_q == ST_IDLE) && awvalid_i && wvalid_i;
  assign rd_go = (state_q == ST_IDLE) && arvalid_i && !awvalid_i;

  assign awready_o = wr_go;
  assign wready_o  = wr_go;
  assign arready_o = rd_go;

  assign cap_addr = awvalid_i ? awaddr_i : araddr_i;
  assign cap_win  = cap_addr & ~`HC_WIN_MASK;

  always_comb begin
    sel_d = SEL_NONE;
    if (cap_win == `HC_PMU_BASE) begin
      sel_d = SEL_PMU;
    end else if (cap_win == `HC_MBOX_BASE) begin
      sel_d = SEL_MBOX;
    end
  end

  // Request towards the selected target until it is taken
  assign req_vld = (state_q == ST_FWD) && !sent_q;

  assign pmu_o.awvalid  = req_vld && is_wr_q && (sel_q == SEL_PMU);
  assign pmu_o.wvalid   = req_vld && is_wr_q && (sel_q == SEL_PMU);
  assign pmu_o.arvalid  = req_vld && !is_wr_q && (sel_q == SEL_PMU);
  assign pmu_o.bready   = (state_q == ST_FWD) && (sel_q == SEL_PMU);
  assign pmu_o.rready   = (state_q == ST_FWD) && (sel_q == SEL_PMU);
  assign pmu_o.awaddr   = addr_q;
  assign pmu_o.araddr   = addr_q;
  assign pmu_o.wdata    = wdata_q;
  assign pmu_o.wstrb    = wstrb_q;

  assign mbox_o.awvalid = req_vld && is_wr_q && (sel_q == SEL_MBOX);
  assign mbox_o.wvalid  = req_vld && is_wr_q && (sel_q == SEL_MBOX);
  assign mbox_o.arvalid = req_vld && !is_wr_q && (sel_q == SEL_MBOX);
  assign mbox_o.bready  = (state_q == ST_FWD) && (sel_q == SEL_MBOX);
  assign mbox_o.rready  = (state_q == ST_FWD) && (sel_q == SEL_MBOX);
  assign mbox_o.awaddr  = addr_q;
  assign mbox_o.araddr  = addr_q;
  assign mbox_o.wdata   = wdata_q;
  assign mbox_o.wstrb   = wstrb_q;

  // Handshake and response of the selected target
  always_comb begin
    t_acc   = 1'b0;
    t_done  = 1'b0;
    t_resp  = RESP_DECERR;
    t_rdata = '0;
    case (sel_q)
      SEL_PMU: begin
        t_acc   = is_wr_q ? (pmu_o.awready && pmu_o.wready) : pmu_o.arready;
        t_done  = is_wr_q ? pmu_o.bvalid : pmu_o.rvalid;
        t_resp  = is_wr_q ? pmu_o.bresp : pmu_o.rresp;
        t_rdata = pmu_o.rdata;
      end
      SEL_MBOX: begin
        t_acc   = is_wr_q ? (mbox_o.awready && mbox_o.wready) : mbox_o.arready;
        t_done  = is_wr_q ? mbox_o.bvalid : mbox_o.rvalid;
        t_resp  = is_wr_q ? mbox_o.bresp : mbox_o.rresp;
        t_rdata = mbox_o.rdata;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
      sel_q   <= SEL_NONE;
      is_wr_q <= 1'b0;
      sent_q  <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (wr_go || rd_go) begin
            state_q <= ST_FWD;
            sel_q   <= sel_d;
            is_wr_q <= wr_go;
            sent_q  <= 1'b0;
          end
        end
        ST_FWD: begin
          if (req_vld && t_acc) begin
            sent_q <= 1'b1;
          end
          if (sel_q == SEL_NONE || (sent_q && t_done)) begin
            state_q <= ST_RESP;
          end
        end
        default: begin
          if ((bvalid_o && bready_i) || (rvalid_o && rready_i)) begin
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_go || rd_go) begin
      addr_q  <= cap_addr & `HC_WIN_MASK;
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
    end
    if (state_q == ST_FWD && (sel_q == SEL_NONE || (sent_q && t_done))) begin
      resp_q  <= t_resp;
      rdata_q <= (sel_q == SEL_NONE || is_wr_q) ? '0 : t_rdata;
    end
  end

  assign bvalid_o = (state_q == ST_RESP) && is_wr_q;
  assign rvalid_o = (state_q == ST_RESP) && !is_wr_q;
  assign bresp_o  = resp_q;
  assign rresp_o  = resp_q;
  assign rdata_o  = rdata_q;

endmodule

//--- src/pmu_counters.sv
`timescale 1ns/1ns
// Performance monitor for last-level cache events
// Saturating counters with an enable mask, a shared threshold
// and one level interrupt per counter

`include "host_ctrl_defs.svh"

module pmu_counters
  import host_ctrl_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  cfg_lite_if.slv                 cfg_i,
  input  llc_evt_t                events_i,
  output logic [`HC_NUM_EVT-1:0]  intr_o
);

  logic [`HC_NUM_EVT-1:0] en_q;
  logic [`HC_DATA_W-1:0]  thr_q;
  logic [`HC_DATA_W-1:0]  cnt_q [`HC_NUM_EVT];
  logic [`HC_NUM_EVT-1:0] evt_vec;
  logic [`HC_NUM_EVT-1:0] intr_q;
  logic                   wr_fire;
  logic                   rd_fire;
  logic                   bvalid_q;
  logic                   rvalid_q;
  axi_resp_e              bresp_q;
  axi_resp_e              rresp_q;
  logic [`HC_DATA_W-1:0]  rdata_q;
  logic [`HC_DATA_W-1:0]  rd_data;

  function automatic logic is_cnt(input logic [`HC_ADDR_W-1:0] ofs, input int idx);
    return ofs == `HC_PMU_CNT_OFS + 4 * idx;
  endfunction

  function automatic logic is_reg(input logic [`HC_ADDR_W-1:0] ofs);
    logic hit;
    hit = (ofs == `HC_PMU_EN_OFS) || (ofs == `HC_PMU_THR_OFS);
    for (int i = 0; i < `HC_NUM_EVT; i++) begin
      hit |= is_cnt(ofs, i);
    end
    return hit;
  endfunction

  assign evt_vec = events_i;

  // Address and data are taken in the same cycle
  assign wr_fire       = cfg_i.awvalid && cfg_i.wvalid && !bvalid_q;
  assign rd_fire       = cfg_i.arvalid && !rvalid_q;
  assign cfg_i.awready = wr_fire;
  assign cfg_i.wready  = wr_fire;
  assign cfg_i.arready = rd_fire;

  always_comb begin
    rd_data = '0;
    if (cfg_i.araddr == `HC_PMU_EN_OFS) begin
      rd_data[`HC_NUM_EVT-1:0] = en_q;
    end else if (cfg_i.araddr == `HC_PMU_THR_OFS) begin
      rd_data = thr_q;
    end
    for (int i = 0; i < `HC_NUM_EVT; i++) begin
      if (is_cnt(cfg_i.araddr, i)) begin
        rd_data = cnt_q[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
      en_q     <= '0;
      thr_q    <= '0;
      intr_q   <= '0;
      for (int i = 0; i < `HC_NUM_EVT; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      bvalid_q <= wr_fire || (bvalid_q && !cfg_i.bready);
      rvalid_q <= rd_fire || (rvalid_q && !cfg_i.rready);
      if (wr_fire && cfg_i.awaddr == `HC_PMU_EN_OFS) begin
        en_q <= cfg_i.wdata[`HC_NUM_EVT-1:0];
      end
      if (wr_fire && cfg_i.awaddr == `HC_PMU_THR_OFS) begin
        thr_q <= cfg_i.wdata;
      end
      for (int i = 0; i < `HC_NUM_EVT; i++) begin
        // Host load wins over counting
        if (wr_fire && is_cnt(cfg_i.awaddr, i)) begin
          cnt_q[i] <= cfg_i.wdata;
        end else if (en_q[i] && evt_vec[i] && cnt_q[i] != '1) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
        intr_q[i] <= en_q[i] && (thr_q != '0) && (cnt_q[i] >= thr_q);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      bresp_q <= is_reg(cfg_i.awaddr) ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_fire) begin
      rresp_q <= is_reg(cfg_i.araddr) ? RESP_OKAY : RESP_SLVERR;
      rdata_q <= rd_data;
    end
  end

  assign cfg_i.bvalid = bvalid_q;
  assign cfg_i.bresp  = bresp_q;
  assign cfg_i.rvalid = rvalid_q;
  assign cfg_i.rresp  = rresp_q;
  assign cfg_i.rdata  = rdata_q;
  assign intr_o       = intr_q;

endmodule

//--- src/h2c_mailbox.sv
`timescale 1ns/1ns
// Host-to-cluster mailbox
// One data word plus a doorbell that raises the cluster interrupt

`include "host_ctrl_defs.svh"

module h2c_mailbox
  import host_ctrl_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  cfg_lite_if.slv  cfg_i,
  output logic     irq_o
);

  logic [`HC_DATA_W-1:0] data_q;
  logic                  irq_q;
  logic                  wr_fire;
  logic                  rd_fire;
  logic                  bvalid_q;
  logic                  rvalid_q;
  axi_resp_e             bresp_q;
  axi_resp_e             rresp_q;
  logic [`HC_DATA_W-1:0] rdata_q;
  logic [`HC_DATA_W-1:0] rd_data;

  function automatic logic is_reg(input logic [`HC_ADDR_W-1:0] ofs);
    return (ofs == `HC_MBOX_DATA_OFS) || (ofs == `HC_MBOX_BELL_OFS) ||
           (ofs == `HC_MBOX_CLR_OFS);
  endfunction

  assign wr_fire       = cfg_i.awvalid && cfg_i.wvalid && !bvalid_q;
  assign rd_fire       = cfg_i.arvalid && !rvalid_q;
  assign cfg_i.awready = wr_fire;
  assign cfg_i.wready  = wr_fire;
  assign cfg_i.arready = rd_fire;

  // Clear offset reads as zero
  always_comb begin
    rd_data = '0;
    if (cfg_i.araddr == `HC_MBOX_DATA_OFS) begin
      rd_data = data_q;
    end else if (cfg_i.araddr == `HC_MBOX_BELL_OFS) begin
      rd_data[0] = irq_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
      data_q   <= '0;
      irq_q    <= 1'b0;
    end else begin
      bvalid_q <= wr_fire || (bvalid_q && !cfg_i.bready);
      rvalid_q <= rd_fire || (rvalid_q && !cfg_i.rready);
      if (wr_fire && cfg_i.awaddr == `HC_MBOX_DATA_OFS) begin
        for (int b = 0; b < `HC_DATA_W / 8; b++) begin
          if (cfg_i.wstrb[b]) begin
            data_q[8*b +: 8] <= cfg_i.wdata[8*b +: 8];
          end
        end
      end
      if (wr_fire && cfg_i.wdata[0]) begin
        if (cfg_i.awaddr == `HC_MBOX_BELL_OFS) begin
          irq_q <= 1'b1;
        end else if (cfg_i.awaddr == `HC_MBOX_CLR_OFS) begin
          irq_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      bresp_q <= is_reg(cfg_i.awaddr) ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_fire) begin
      rresp_q <= is_reg(cfg_i.araddr) ? RESP_OKAY : RESP_SLVERR;
      rdata_q <= rd_data;
    end
  end

  assign cfg_i.bvalid = bvalid_q;
  assign cfg_i.bresp  = bresp_q;
  assign cfg_i.rvalid = rvalid_q;
  assign cfg_i.rresp  = rresp_q;
  assign cfg_i.rdata  = rdata_q;
  assign irq_o        = irq_q;

endmodule

//--- src/host_ctrl_domain.sv
`timescale 1ns/1ns
// Host control domain
// Host AXI4-Lite config port split between the cache event monitor
// and the host-to-cluster mailbox

`include "host_ctrl_defs.svh"

module host_ctrl_domain
  import host_ctrl_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     awvalid_i,
  output logic                     awready_o,
  input  logic [`HC_ADDR_W-1:0]    awaddr_i,
  input  logic                     wvalid_i,
  output logic                     wready_o,
  input  logic [`HC_DATA_W-1:0]    wdata_i,
  input  logic [`HC_DATA_W/8-1:0]  wstrb_i,
  output logic                     bvalid_o,
  input  logic                     bready_i,
  output axi_resp_e                bresp_o,
  input  logic                     arvalid_i,
  output logic                     arready_o,
  input  logic [`HC_ADDR_W-1:0]    araddr_i,
  output logic                     rvalid_o,
  input  logic                     rready_i,
  output logic [`HC_DATA_W-1:0]    rdata_o,
  output axi_resp_e                rresp_o,
  input  llc_evt_t                 llc_events_i,
  output logic [`HC_NUM_EVT-1:0]   pmu_intr_o,
  output logic                     h2c_irq_o
);

  cfg_lite_if pmu_cfg_bus ();
  cfg_lite_if mbox_cfg_bus ();

  lite_demux i_lite_demux (
    .clk_i     ( clk_i        ),
    .reset_i   ( reset_i      ),
    .awvalid_i ( awvalid_i    ),
    .awready_o ( awready_o    ),
    .awaddr_i  ( awaddr_i     ),
    .wvalid_i  ( wvalid_i     ),
    .wready_o  ( wready_o     ),
    .wdata_i   ( wdata_i      ),
    .wstrb_i   ( wstrb_i      ),
    .bvalid_o  ( bvalid_o     ),
    .bready_i  ( bready_i     ),
    .bresp_o   ( bresp_o      ),
    .arvalid_i ( arvalid_i    ),
    .arready_o ( arready_o    ),
    .araddr_i  ( araddr_i     ),
    .rvalid_o  ( rvalid_o     ),
    .rready_i  ( rready_i     ),
    .rdata_o   ( rdata_o      ),
    .rresp_o   ( rresp_o      ),
    .pmu_o     ( pmu_cfg_bus  ),
    .mbox_o    ( mbox_cfg_bus )
  );

  pmu_counters i_pmu_counters (
    .clk_i    ( clk_i        ),
    .reset_i  ( reset_i      ),
    .cfg_i    ( pmu_cfg_bus  ),
    .events_i ( llc_events_i ),
    .intr_o   ( pmu_intr_o   )
  );

  h2c_mailbox i_h2c_mailbox (
    .clk_i   ( clk_i        ),
    .reset_i ( reset_i      ),
    .cfg_i   ( mbox_cfg_bus ),
    .irq_o   ( h2c_irq_o    )
  );

endmodule

//--- sim/tb_host_ctrl_domain.sv
`timescale 1ns/1ns
// Testbench for the host control domain
// Replays golden vectors over the AXI4-Lite port with random response stalls

`include "host_ctrl_defs.svh"

module tb_host_ctrl_domain
  import host_ctrl_pkg::*;
();

  localparam int FIELDS    = 7;
  localparam int MAX_LINES = 64;

  logic                    clk_i;
  logic                    reset_i;
  logic                    awvalid;
  logic                    awready;
  logic [`HC_ADDR_W-1:0]   awaddr;
  logic                    wvalid;
  logic                    wready;
  logic [`HC_DATA_W-1:0]   wdata;
  logic [`HC_DATA_W/8-1:0] wstrb;
  logic                    bvalid;
  logic                    bready;
  logic [1:0]              bresp;
  logic                    arvalid;
  logic                    arready;
  logic [`HC_ADDR_W-1:0]   araddr;
  logic                    rvalid;
  logic                    rready;
  logic [`HC_DATA_W-1:0]   rdata;
  logic [1:0]              rresp;
  llc_evt_t                llc_events;
  logic [`HC_NUM_EVT-1:0]  pmu_intr;
  logic                    h2c_irq;

  logic [31:0] gold_mem [0:FIELDS*MAX_LINES-1];
  logic [31:0] rng_q;
  int          num_lines;
  int          cycle_count;
  int          timeout_limit;

  host_ctrl_domain u_host_ctrl_domain (
    .clk_i        ( clk_i      ),
    .reset_i      ( reset_i    ),
    .awvalid_i    ( awvalid    ),
    .awready_o    ( awready    ),
    .awaddr_i     ( awaddr     ),
    .wvalid_i     ( wvalid     ),
    .wready_o     ( wready     ),
    .wdata_i      ( wdata      ),
    .wstrb_i      ( wstrb      ),
    .bvalid_o     ( bvalid     ),
    .bready_i     ( bready     ),
    .bresp_o      ( bresp      ),
    .arvalid_i    ( arvalid    ),
    .arready_o    ( arready    ),
    .araddr_i     ( araddr     ),
    .rvalid_o     ( rvalid     ),
    .rready_i     ( rready     ),
    .rdata_o      ( rdata      ),
    .rresp_o      ( rresp      ),
    .llc_events_i ( llc_events ),
    .pmu_intr_o   ( pmu_intr   ),
    .h2c_irq_o    ( h2c_irq    )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
      $display("Timeout: the DUT did not finish the golden vectors in %0d cycles",
               timeout_limit);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
    if (got !== exp) begin
      $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  // Random hold-off of 0 to 3 cycles before ready goes high
  task automatic stall_response();
    rng_q = next_rand(rng_q);
    @(posedge clk_i);
    repeat (rng_q[1:0]) @(posedge clk_i);
    #1;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
    @(posedge clk_i);
    #1;
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    wstrb   = strb;
    @(negedge clk_i);
    while (!(awready && wready)) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(negedge clk_i);
    while (!bvalid) @(negedge clk_i);
    stall_response();
    bready = 1'b1;
    @(negedge clk_i);
    // The response stays up while bready is held low
    compare_value(32'(bvalid), 32'h1, $sformatf("write response valid at %h", addr));
    resp = bresp;
    @(posedge clk_i);
    #1;
    bready = 1'b0;
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    @(posedge clk_i);
    #1;
    arvalid = 1'b1;
    araddr  = addr;
    @(negedge clk_i);
    while (!arready) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    arvalid = 1'b0;
    @(negedge clk_i);
    while (!rvalid) @(negedge clk_i);
    stall_response();
    rready = 1'b1;
    @(negedge clk_i);
    compare_value(32'(rvalid), 32'h1, $sformatf("read response valid at %h", addr));
    resp = rresp;
    data = rdata;
    @(posedge clk_i);
    #1;
    rready = 1'b0;
  endtask

  // Counters and interrupts settle two cycles after the last event
  task automatic pulse_events(input int cycles, input logic [3:0] vec);
    @(posedge clk_i);
    #1;
    llc_events = llc_evt_t'(vec);
    repeat (cycles) @(posedge clk_i);
    #1;
    llc_events = '0;
    repeat (2) @(posedge clk_i);
  endtask

  initial begin
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp_resp;
    logic [31:0] exp_rdata;
    logic [31:0] exp_irq;
    logic [31:0] got_rdata;
    logic [1:0]  got_resp;
    int          base;
    reset_i       = 1'b1;
    awvalid       = 1'b0;
    awaddr        = '0;
    wvalid        = 1'b0;
    wdata         = '0;
    wstrb         = '0;
    bready        = 1'b0;
    arvalid       = 1'b0;
    araddr        = '0;
    rready        = 1'b0;
    llc_events    = '0;
    cycle_count   = 0;
    timeout_limit = 0;
    rng_q         = 32'ha9815e62;
    $readmemh("sim/golden_vectors.txt", gold_mem);
    num_lines = 0;
    while (num_lines < MAX_LINES && gold_mem[FIELDS*num_lines] !== 32'hf) begin
      num_lines++;
    end
    if (num_lines == 0 || num_lines == MAX_LINES) begin
      $display("The golden file holds no operations or lacks its end marker");
      $display("SIMULATION FAILED");
      $fatal(1, "bad golden file");
    end
    timeout_limit = 200 * num_lines;
    repeat (8) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // Handshake outputs and interrupts come out of reset low
    @(negedge clk_i);
    compare_value({27'b0, awready, wready, arready, bvalid, rvalid}, 32'h0,
                  "handshake outputs after reset");
    compare_value({27'b0, h2c_irq, pmu_intr}, 32'h0, "interrupts after reset");

    for (int i = 0; i < num_lines; i++) begin
      base      = FIELDS * i;
      op        = gold_mem[base];
      addr      = gold_mem[base+1];
      data      = gold_mem[base+2];
      exp_resp  = gold_mem[base+4];
      exp_rdata = gold_mem[base+5];
      exp_irq   = gold_mem[base+6];
      case (op)
        32'h1: begin
          bus_write(addr, data, gold_mem[base+3][3:0], got_resp);
          compare_value(32'(got_resp), exp_resp, $sformatf("write response at %h", addr));
        end
        32'h2: begin
          bus_read(addr, got_rdata, got_resp);
          compare_value(32'(got_resp), exp_resp, $sformatf("read response at %h", addr));
          compare_value(got_rdata, exp_rdata, $sformatf("read data at %h", addr));
        end
        32'h3: pulse_events(int'(data), gold_mem[base+3][3:0]);
        32'h4: repeat (int'(data)) @(posedge clk_i);
        default: begin
          $display("Unknown opcode %h on golden line %0d", op, i);
          $display("SIMULATION FAILED");
          $fatal(1, "bad opcode");
        end
      endcase
      @(negedge clk_i);
      compare_value({27'b0, h2c_irq, pmu_intr}, exp_irq,
                    $sformatf("interrupts after line %0d", i));
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- sim/golden_vectors.txt
// op addr data strb resp rdata irq; op 1 write, 2 read, 3 events, 4 idle, f end
// events: data = cycle count, strb = event vector; irq = {h2c_irq, pmu_intr[3:0]}
1 00000100 11223344 f 0 00000000 00
1 00000100 aabbccdd 5 0 00000000 00
2 00000100 00000000 0 0 11bb33dd 00
1 00000104 00000001 f 0 00000000 10
2 00000104 00000000 0 0 00000001 10
1 00000108 00000001 f 0 00000000 00
2 00000104 00000000 0 0 00000000 00
1 00000104 00000002 f 0 00000000 00
2 00000108 00000000 0 0 00000000 00
1 00000000 00000005 f 0 00000000 00
2 00000000 00000000 0 0 00000005 00
3 00000000 00000005 f 0 00000000 00
2 00000010 00000000 0 0 00000005 00
2 00000014 00000000 0 0 00000000 00
2 00000018 00000000 0 0 00000005 00
2 0000001c 00000000 0 0 00000000 00
1 00000004 00000008 f 0 00000000 00
2 00000004 00000000 0 0 00000008 00
3 00000000 00000005 f 0 00000000 05
2 00000010 00000000 0 0 0000000a 05
1 00000010 00000000 f 0 00000000 04
2 00000010 00000000 0 0 00000000 04
1 00000018 ffffffff f 0 00000000 04
3 00000000 00000003 f 0 00000000 04
2 00000018 00000000 0 0 ffffffff 04
2 00000010 00000000 0 0 00000003 04
1 00000300 12345678 f 3 00000000 04
2 00000300 00000000 0 3 00000000 04
2 00000008 00000000 0 2 00000000 04
1 0000010c 00000001 f 2 00000000 04
4 00000000 00000004 0 0 00000000 04
f 00000000 00000000 0 0 00000000 00

//--- flist.f
+incdir+include
src/host_ctrl_pkg.sv
src/cfg_lite_if.sv
src/lite_demux.sv
src/pmu_counters.sv
src/h2c_mailbox.sv
src/host_ctrl_domain.sv
sim/tb_host_ctrl_domain.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the host control domain testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f flist.f \
  --top-module tb_host_ctrl_domain -o tb_host_ctrl_domain

./obj_dir/tb_host_ctrl_domain | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "Test failed, see sim.log"
  exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
  echo "Test did not finish, see sim.log"
  exit 1
fi
